/* gem_rx.f */
hdl/gem_link_pkg.sv
hdl/gem_rx_pkg.sv
hdl/gem_frame_aligner.sv
hdl/gem_link_monitor.sv
hdl/gem_prbs_checker.sv
hdl/gem_rx_delay_line.sv
hdl/gem_optical_rx.sv
hdl/gem_rx_top.sv
testbench/gem_rx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the receiver testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module gem_rx_tb -f gem_rx.f --Mdir obj_dir -o gem_rx_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/gem_rx_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Everything OK"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* testbench/gem_rx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module gem_rx_tb;
  import gem_link_pkg::*;
  import gem_rx_pkg::*;

  typedef struct packed {
    logic       known;                              // Delay tap already holds a sent frame
    gem_frame_s frame;
    logic       fc;
    logic       chk;                                // PRBS compare made on this frame
    logic       match;
    logic       had_err;
    logic       good;
    logic       bad;
    err_count_t err_count;
  } expect_s;

  logic                        clock = 1'b0;
  logic                        gtx_rx_reset;
  logic                        clear_sync;
  logic                        ttc_resync;
  logic                        prbs_mode;
  delay_t                      delay_is;
  logic [NUM_FIBERS-1:0]       pol_swap;
  link_word_s [NUM_FIBERS-1:0] rx_word;
  rx_status_s [NUM_FIBERS-1:0] rx_status;
  gem_frame_s [NUM_FIBERS-1:0] rx_frame;
  logic [NUM_FIBERS-1:0]       rx_frame_strobe;
  rx_markers_s [NUM_FIBERS-1:0] rx_markers;

  integer     seed = 32'h3e6aafa0;
  int         errors = 0;
  int         checks = 0;
  bit         checking = 1'b0;                      // Output monitor enabled
  delay_t     cur_delay = '0;                       // Applied with word 2 of each frame
  logic       cur_prbs = 1'b0;

  // ------------------------------------------------------------------------
  // Reference model state, one entry per fiber
  // ------------------------------------------------------------------------
  k_char_t     tx_k [NUM_FIBERS];                   // Next frame to send
  gem_data_t   tx_d [NUM_FIBERS];
  gem_data_t   gen [NUM_FIBERS];                    // Clean PRBS sequence
  link_count_t m_errs [NUM_FIBERS];
  int          m_good_cnt [NUM_FIBERS];
  logic        m_had [NUM_FIBERS];
  logic        m_good [NUM_FIBERS];
  logic        m_bad [NUM_FIBERS];
  logic        m_seeded [NUM_FIBERS];
  gem_data_t   m_last [NUM_FIBERS];
  err_count_t  m_pcnt [NUM_FIBERS];
  gem_frame_s  hist [NUM_FIBERS][DELAY_DEPTH];      // Newest first
  int          hist_n [NUM_FIBERS];
  expect_s     exp_q [NUM_FIBERS][$];               // Frames waiting for an output strobe
  expect_s     pend_e [NUM_FIBERS];                 // Status check one cycle after strobe
  logic        pend [NUM_FIBERS];
  int          start_cnt [NUM_FIBERS];

  gem_rx_top i_gem_rx_top (
    .clock, .gtx_rx_reset, .clear_sync, .ttc_resync, .prbs_mode, .delay_is, .pol_swap,
    .rx_word, .rx_status, .rx_frame, .rx_frame_strobe, .rx_markers
  );

  always #5 clock = ~clock;

  // Fibonacci step, taps 48 47 21 20
  function automatic gem_data_t lfsr_advance(input gem_data_t d);
    return {d[46:0], d[47] ^ d[46] ^ d[20] ^ d[19]};
  endfunction

  function automatic gem_data_t rand48();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[47:0];
  endfunction

  function automatic k_char_t rand_k();
    int unsigned r;
    r = $random(seed);
    case (r % 5)
      0:       return 8'h00;
      1:       return K_OVERFLOW;
      2:       return K_BC0;
      3:       return K_RESYNC;
      default: return K_LATENCY;
    endcase
  endfunction

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Link health, substitution, delay tap and PRBS compare for one frame
  task automatic model_frame(input int f, input logic bad, input logic resync);
    gem_frame_s in_f;
    expect_s    e;
    if (resync) begin
      m_errs[f]     = '0;
      m_good_cnt[f] = 0;
      m_had[f]      = 1'b0;
      m_good[f]     = 1'b0;
      m_bad[f]      = 1'b0;
    end
    if (bad) begin                                  // No strobe, lock lost
      if (m_errs[f] != 8'hFF) m_errs[f]++;
      if (m_errs[f] >= link_count_t'(BAD_ERRORS)) m_bad[f] = 1'b1;
      m_had[f]      = 1'b1;
      m_good[f]     = 1'b0;
      m_good_cnt[f] = 0;
      m_seeded[f]   = 1'b0;
    end else begin
      in_f.k_char = tx_k[f];
      in_f.data   = tx_d[f];
      if (!m_good[f] || m_bad[f]) begin             // Link state before this frame
        in_f.data   = '1;
        in_f.k_char = '0;
      end
      if (!m_good[f]) begin
        m_good_cnt[f]++;
        if (m_good_cnt[f] == GOOD_FRAMES) m_good[f] = 1'b1;
      end
      for (int i = DELAY_DEPTH - 1; i > 0; i--) hist[f][i] = hist[f][i-1];
      hist[f][0] = in_f;
      if (hist_n[f] < DELAY_DEPTH) hist_n[f]++;
      e.known = int'(cur_delay) < hist_n[f];
      e.frame = hist[f][cur_delay];
      e.fc    = (tx_k[f] == K_LATENCY);             // Undelayed frame
      e.chk   = m_seeded[f];
      e.match = (tx_d[f] == lfsr_advance(m_last[f]));
      if (e.chk && cur_prbs && !e.match) m_pcnt[f]++;
      if (!cur_prbs) m_pcnt[f] = '0;
      m_last[f]   = tx_d[f];
      m_seeded[f] = 1'b1;
      e.had_err   = m_had[f];
      e.good      = m_good[f];
      e.bad       = m_bad[f];
      e.err_count = cur_prbs ? m_pcnt[f] : err_count_t'(m_errs[f]);
      exp_q[f].push_back(e);
    end
  endtask

  // Four words per fiber from tx_k/tx_d, one per clock
  task automatic send_frames(input logic [NUM_FIBERS-1:0] bad, input logic resync);
    link_word_s w;
    for (int i = 0; i < FRAME_WORDS; i++) begin
      for (int f = 0; f < NUM_FIBERS; f++) begin
        case (i)
          0:       w = {1'b1, K_COMMA, tx_k[f]};
          1:       w = {1'b0, tx_d[f][47:32]};
          2:       w = {1'b0, tx_d[f][31:16]};
          default: w = {1'b0, tx_d[f][15:0]};
        endcase
        if (i == 0 && bad[f]) w.is_k = 1'b0;        // Comma byte sent as data
        if (pol_swap[f]) w.data = ~w.data;
        rx_word[f] = w;
      end
      if (i == 2) begin                             // Clear of any strobe in flight
        ttc_resync = resync;
        delay_is   = cur_delay;
        prbs_mode  = cur_prbs;
      end
      if (i == 3) ttc_resync = 1'b0;
      @(posedge clock);
      #1;
    end
    for (int f = 0; f < NUM_FIBERS; f++) model_frame(f, bad[f], resync);
  endtask

  task automatic random_frames(input int n, input logic [NUM_FIBERS-1:0] bad,
                               input logic resync);
    repeat (n) begin
      for (int f = 0; f < NUM_FIBERS; f++) begin
        tx_k[f] = rand_k();
        tx_d[f] = rand48();
      end
      send_frames(bad, resync);
    end
  endtask

  task automatic send_idle(input int n);
    repeat (n) begin
      for (int f = 0; f < NUM_FIBERS; f++) rx_word[f] = {1'b0, link_data_t'($random(seed))};
      @(posedge clock);
      #1;
    end
  endtask

  task automatic check_link(input int errs, input logic had, input logic bad);
    for (int f = 0; f < NUM_FIBERS; f++) begin
      check($sformatf("fiber%0d err_count", f), errs, rx_status[f].err_count);
      check($sformatf("fiber%0d link_had_err", f), had, rx_status[f].link_had_err);
      check($sformatf("fiber%0d link_bad", f), bad, rx_status[f].link_bad);
    end
  endtask

  // ------------------------------------------------------------------------
  // Output monitor, sampled mid-cycle
  // ------------------------------------------------------------------------
  always @(negedge clock) begin
    expect_s e;
    if (checking) begin
      for (int f = 0; f < NUM_FIBERS; f++) begin
        if (rx_status[f].start) start_cnt[f]++;
        if (pend[f]) begin                          // Status two cycles after frame strobe
          pend[f] = 1'b0;
          e = pend_e[f];
          check($sformatf("fiber%0d link_had_err", f), e.had_err, rx_status[f].link_had_err);
          check($sformatf("fiber%0d link_good", f), e.good, rx_status[f].link_good);
          check($sformatf("fiber%0d link_bad", f), e.bad, rx_status[f].link_bad);
          check($sformatf("fiber%0d err_count", f), e.err_count, rx_status[f].err_count);
          if (e.chk) begin
            check($sformatf("fiber%0d match", f), e.match, rx_status[f].match);
            check($sformatf("fiber%0d err", f), !e.match, rx_status[f].err);
          end
        end
        if (rx_frame_strobe[f]) begin
          if (exp_q[f].size() == 0) begin
            errors++;
            $display("Fiber %0d gave an output frame that was never sent", f);
          end else begin
            e = exp_q[f].pop_front();
            if (e.known) begin
              check($sformatf("fiber%0d frame", f), e.frame, rx_frame[f]);
              check($sformatf("fiber%0d markers", f),
                    {e.frame.k_char == K_OVERFLOW, e.frame.k_char == K_BC0,
                     e.frame.k_char == K_RESYNC}, rx_markers[f]);
            end
            check($sformatf("fiber%0d fc", f), e.fc, rx_status[f].fc);
            pend_e[f] = e;
            pend[f]   = 1'b1;
          end
        end else begin
          check($sformatf("fiber%0d fc idle", f), 1'b0, rx_status[f].fc);
        end
      end
    end
  end

  initial begin
    int n;
    gtx_rx_reset = 1'b1;
    clear_sync   = 1'b0;
    ttc_resync   = 1'b0;
    prbs_mode    = 1'b0;
    delay_is     = '0;
    pol_swap     = 2'b10;                           // Fiber 1 routed swapped
    rx_word      = '0;
    for (int f = 0; f < NUM_FIBERS; f++) begin
      m_errs[f]     = '0;
      m_good_cnt[f] = 0;
      m_had[f]      = 1'b0;
      m_good[f]     = 1'b0;
      m_bad[f]      = 1'b0;
      m_seeded[f]   = 1'b0;
      m_pcnt[f]     = '0;
      hist_n[f]     = 0;
      pend[f]       = 1'b0;
      start_cnt[f]  = 0;
    end
    repeat (5) @(posedge clock);
    #1 gtx_rx_reset = 1'b0;
    for (int f = 0; f < NUM_FIBERS; f++) check($sformatf("fiber%0d reset status", f), '0,
                                               rx_status[f]);
    check("reset strobes", '0, rx_frame_strobe);
    checking = 1'b1;

    // Alignment from a random word offset
    n = 1 + int'($unsigned($random(seed)) % 7);
    send_idle(n);
    for (int f = 0; f < NUM_FIBERS; f++) check($sformatf("fiber%0d valid", f), 1'b0,
                                               rx_status[f].valid);
    random_frames(3, '0, 1'b0);
    for (int f = 0; f < NUM_FIBERS; f++) begin
      check($sformatf("fiber%0d valid", f), 1'b1, rx_status[f].valid);
      check($sformatf("fiber%0d sync_done", f), 1'b1, rx_status[f].sync_done);
    end
    random_frames(21, '0, 1'b0);                    // Past link_good, payload visible
    for (int f = 0; f < NUM_FIBERS; f++) check($sformatf("fiber%0d start pulses", f), 1,
                                               start_cnt[f]);

    // Delay line and markers
    cur_delay = 4'd0;
    random_frames(40, '0, 1'b0);
    cur_delay = 4'd5;
    random_frames(40, '0, 1'b0);
    cur_delay = 4'd15;
    random_frames(40, '0, 1'b0);

    // Link errors, then ttc_resync
    cur_delay = 4'd3;
    repeat (5) begin
      random_frames(1, '1, 1'b0);                   // Missing comma
      random_frames(2, '0, 1'b0);
    end
    check_link(5, 1'b1, 1'b0);
    repeat (3) begin
      random_frames(1, '1, 1'b0);
      random_frames(2, '0, 1'b0);
    end
    check_link(8, 1'b1, 1'b1);
    random_frames(20, '0, 1'b0);                    // Substituted while bad
    random_frames(1, '0, 1'b1);
    random_frames(2, '0, 1'b0);
    check_link(0, 1'b0, 1'b0);
    random_frames(20, '0, 1'b0);

    // PRBS payloads with random corruption
    cur_prbs = 1'b1;
    for (int f = 0; f < NUM_FIBERS; f++) gen[f] = rand48() | 48'h1;
    repeat (60) begin
      for (int f = 0; f < NUM_FIBERS; f++) begin
        tx_k[f] = rand_k();
        tx_d[f] = gen[f];
        if (($random(seed) & 7) == 0) tx_d[f] = tx_d[f] ^ (rand48() | 48'h1);
        gen[f] = lfsr_advance(gen[f]);
      end
      send_frames('0, 1'b0);
    end
    cur_prbs = 1'b0;
    random_frames(2, '0, 1'b0);

    // Let the last frames leave the delay line
    send_idle(1);
    n = 0;
    while ((exp_q[0].size() != 0 || exp_q[1].size() != 0 || pend[0] || pend[1]) && n < 20) begin
      @(posedge clock);
      n++;
    end
    if (exp_q[0].size() != 0 || exp_q[1].size() != 0 || pend[0] || pend[1]) begin
      $display("Timeout: output frames still missing after the last frame was sent");
      $display("Something failed");
      $finish;
    end else begin
      checking = 1'b0;

      // clear_sync zeroes the status register
      @(posedge clock);
      #1 clear_sync = 1'b1;
      @(posedge clock);
      #1 clear_sync = 1'b0;
      for (int f = 0; f < NUM_FIBERS; f++) check($sformatf("fiber%0d clear_sync", f), '0,
                                                 rx_status[f]);
      repeat (2) @(posedge clock);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("Everything OK");
      end else begin
        $display("Something failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* hdl/gem_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gem_rx_top (
  input  logic                                                  clock,
  input  logic                                                  gtx_rx_reset,
  input  logic                                                  clear_sync,
  input  logic                                                  ttc_resync,
  input  logic                                                  prbs_mode,
  input  gem_rx_pkg::delay_t                                    delay_is,
  input  logic [gem_rx_pkg::NUM_FIBERS-1:0]                     pol_swap,
  input  gem_link_pkg::link_word_s [gem_rx_pkg::NUM_FIBERS-1:0] rx_word,
  output gem_rx_pkg::rx_status_s [gem_rx_pkg::NUM_FIBERS-1:0]   rx_status,
  output gem_link_pkg::gem_frame_s [gem_rx_pkg::NUM_FIBERS-1:0] rx_frame,
  output logic [gem_rx_pkg::NUM_FIBERS-1:0]                     rx_frame_strobe,
  output gem_rx_pkg::rx_markers_s [gem_rx_pkg::NUM_FIBERS-1:0]  rx_markers
);
  import gem_rx_pkg::*;

  // One receiver per fiber, control inputs shared
  for (genvar i = 0; i < NUM_FIBERS; i++) begin : g_fiber
    gem_optical_rx i_optical_rx (
      .clock, .gtx_rx_reset, .clear_sync, .ttc_resync, .prbs_mode, .delay_is,
      .pol_swap        (pol_swap[i]),
      .rx_word         (rx_word[i]),
      .rx_status       (rx_status[i]),
      .rx_frame        (rx_frame[i]),
      .rx_frame_strobe (rx_frame_strobe[i]),
      .rx_markers      (rx_markers[i])
    );
  end

endmodule

`default_nettype wire

/* hdl/gem_optical_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module gem_optical_rx (
  input  logic                     clock,
  input  logic                     gtx_rx_reset,
  input  logic                     clear_sync,       // Zeroes the status register
  input  logic                     ttc_resync,
  input  logic                     prbs_mode,
  input  gem_rx_pkg::delay_t       delay_is,
  input  logic                     pol_swap,
  input  gem_link_pkg::link_word_s rx_word,
  output gem_rx_pkg::rx_status_s   rx_status,
  output gem_link_pkg::gem_frame_s rx_frame,
  output logic                     rx_frame_strobe,
  output gem_rx_pkg::rx_markers_s  rx_markers
);
  import gem_link_pkg::*;
  import gem_rx_pkg::*;

  gem_frame_s  frame;
  logic        frame_strobe;
  logic        frame_err;
  logic        locked;
  logic        start_pulse;
  link_count_t link_errors;
  logic        link_had_err;
  logic        link_good;
  logic        link_bad;
  logic        match;
  logic        err;
  err_count_t  prbs_errors;

  gem_frame_aligner i_aligner (
    .clock, .gtx_rx_reset, .rx_word, .pol_swap,
    .frame, .frame_strobe, .frame_err, .locked, .start_pulse
  );

  gem_link_monitor i_link_monitor (
    .clock, .gtx_rx_reset, .ttc_resync, .frame_strobe, .frame_err,
    .link_errors, .link_had_err, .link_good, .link_bad
  );

  gem_prbs_checker i_prbs_checker (
    .clock, .gtx_rx_reset, .prbs_mode, .frame_strobe, .locked, .frame,
    .match, .err, .prbs_errors
  );

  gem_rx_delay_line i_delay_line (
    .clock, .gtx_rx_reset, .frame_strobe, .link_good, .link_bad, .frame, .delay_is,
    .out_frame  (rx_frame),
    .out_strobe (rx_frame_strobe),
    .markers    (rx_markers)
  );

  // --------------------------------------------------------------------------
  // Status register, one cycle behind the submodules
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      rx_status <= '0;
    end else if (clear_sync) begin
      rx_status <= '0;
    end else begin
      rx_status.start        <= start_pulse;
      rx_status.fc           <= frame_strobe && (frame.k_char == K_LATENCY);  // Latency code
      rx_status.valid        <= locked;
      rx_status.sync_done    <= locked;         // Readiness is frame lock
      rx_status.match        <= match;
      rx_status.err          <= err;
      rx_status.link_had_err <= link_had_err;
      rx_status.link_good    <= link_good;
      rx_status.link_bad     <= link_bad;
      rx_status.err_count    <= prbs_mode ? prbs_errors : err_count_t'(link_errors);
    end
  end

endmodule

`default_nettype wire

/* hdl/gem_rx_delay_line.sv */
`timescale 1ns/1ps
`default_nettype none

module gem_rx_delay_line (
  input  logic                     clock,
  input  logic                     gtx_rx_reset,
  input  logic                     frame_strobe,
  input  logic                     link_good,
  input  logic                     link_bad,
  input  gem_link_pkg::gem_frame_s frame,
  input  gem_rx_pkg::delay_t       delay_is,      // Frames of delay
  output gem_link_pkg::gem_frame_s out_frame,
  output logic                     out_strobe,
  output gem_rx_pkg::rx_markers_s  markers
);
  import gem_link_pkg::*;
  import gem_rx_pkg::*;

  gem_frame_s in_frame;
  gem_frame_s hist [DELAY_DEPTH-1];               // Earlier frames, newest first
  gem_frame_s taps [DELAY_DEPTH];                 // Tap 0 is the incoming frame
  gem_frame_s sel;
  logic       ignore_link;

  assign ignore_link = !link_good || link_bad;    // Keep bad links out of the trigger

  always_comb begin
    in_frame = frame;
    if (ignore_link) begin
      in_frame.data   = '1;
      in_frame.k_char = '0;
    end
    taps[0] = in_frame;
    for (int i = 1; i < DELAY_DEPTH; i++) taps[i] = hist[i-1];
    sel = taps[delay_is];
  end

  always_ff @(posedge clock) begin
    if (frame_strobe) begin
      hist[0] <= in_frame;
      for (int i = 1; i < DELAY_DEPTH - 1; i++) hist[i] <= hist[i-1];
      out_frame <= sel;
    end
  end

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      out_strobe <= 1'b0;
      markers    <= '0;
    end else begin
      out_strobe <= frame_strobe;
      if (frame_strobe) begin                     // Held with out_frame
        markers.overflow <= (sel.k_char == K_OVERFLOW);
        markers.bc0      <= (sel.k_char == K_BC0);
        markers.resync   <= (sel.k_char == K_RESYNC);
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/gem_prbs_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module gem_prbs_checker (
  input  logic                     clock,
  input  logic                     gtx_rx_reset,
  input  logic                     prbs_mode,     // Count mismatches
  input  logic                     frame_strobe,
  input  logic                     locked,
  input  gem_link_pkg::gem_frame_s frame,
  output logic                     match,
  output logic                     err,
  output gem_rx_pkg::err_count_t   prbs_errors
);
  import gem_link_pkg::*;
  import gem_rx_pkg::*;

  gem_data_t last_data;                           // Previous payload, seeds the next step
  gem_data_t expected;
  logic      seeded;                              // last_data holds a frame of this lock
  logic      data_ok;

  // Fibonacci LFSR step, taps 48 47 21 20
  function automatic gem_data_t prbs_step(input gem_data_t d);
    return {d[46:0], d[47] ^ d[46] ^ d[20] ^ d[19]};
  endfunction

  assign expected = prbs_step(last_data);
  assign data_ok  = (frame.data == expected);

  always_ff @(posedge clock) begin
    if (frame_strobe) last_data <= frame.data;    // Self seeding
  end

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      seeded      <= 1'b0;
      match       <= 1'b0;
      err         <= 1'b0;
      prbs_errors <= '0;
    end else begin
      if (!locked) seeded <= 1'b0;                // Reseed after lock loss
      else if (frame_strobe) seeded <= 1'b1;
      if (frame_strobe && seeded) begin
        match <= data_ok;
        err   <= !data_ok;
        if (prbs_mode && !data_ok) prbs_errors <= prbs_errors + 1'b1;  // Wraps
      end
      if (!prbs_mode) prbs_errors <= '0;
    end
  end

endmodule

`default_nettype wire

/* hdl/gem_link_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module gem_link_monitor (
  input  logic                    clock,
  input  logic                    gtx_rx_reset,
  input  logic                    ttc_resync,    // Clears counters and flags
  input  logic                    frame_strobe,
  input  logic                    frame_err,
  output gem_rx_pkg::link_count_t link_errors,   // Saturating error count
  output logic                    link_had_err,  // Sticky
  output logic                    link_good,
  output logic                    link_bad
);
  import gem_rx_pkg::*;

  link_count_t good_cnt;                          // Clean frames in a row

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      link_errors  <= '0;
      good_cnt     <= '0;
      link_had_err <= 1'b0;
      link_good    <= 1'b0;
      link_bad     <= 1'b0;
    end else if (ttc_resync) begin
      link_errors  <= '0;
      good_cnt     <= '0;
      link_had_err <= 1'b0;
      link_good    <= 1'b0;
      link_bad     <= 1'b0;
    end else if (frame_err) begin
      if (link_errors != '1) link_errors <= link_errors + 1'b1;
      if (link_errors >= link_count_t'(BAD_ERRORS - 1)) link_bad <= 1'b1;  // Count after this one
      link_had_err <= 1'b1;
      link_good    <= 1'b0;                       // Any error restarts the run
      good_cnt     <= '0;
    end else if (frame_strobe && !link_good) begin
      good_cnt <= good_cnt + 1'b1;
      if (good_cnt == link_count_t'(GOOD_FRAMES - 1)) link_good <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/gem_frame_aligner.sv */
`timescale 1ns/1ps
`default_nettype none

module gem_frame_aligner (
  input  logic                     clock,
  input  logic                     gtx_rx_reset,
  input  gem_link_pkg::link_word_s rx_word,       // One word per clock
  input  logic                     pol_swap,      // Board route swaps the pair
  output gem_link_pkg::gem_frame_s frame,         // Last complete frame
  output logic                     frame_strobe,  // New frame on frame
  output logic                     frame_err,     // Framing violation
  output logic                     locked,        // Frame boundary held
  output logic                     start_pulse    // First frame after lock
);
  import gem_link_pkg::*;

  typedef enum logic {HUNT, LOCKED} state_e;

  state_e                         state;
  logic [$clog2(FRAME_WORDS)-1:0] pos;            // Position of the incoming word
  link_data_t                     word_data;
  logic                           is_comma;
  logic                           violation;
  logic                           frame_done;
  logic                           first_frame;    // Waiting for first frame after lock
  k_char_t                        k_hold;         // K char of frame in progress
  link_data_t [1:0]               held;           // Data words 1 and 2

  assign word_data  = pol_swap ? ~rx_word.data : rx_word.data;  // is_k is not swapped
  assign is_comma   = rx_word.is_k && (word_data[15:8] == K_COMMA);
  assign violation  = (pos == '0) ? !is_comma : rx_word.is_k;   // Checked in LOCKED only
  assign frame_done = (state == LOCKED) && !violation
                      && (pos == $bits(pos)'(FRAME_WORDS - 1));

  // --------------------------------------------------------------------------
  // Framing FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      state        <= HUNT;
      pos          <= '0;
      locked       <= 1'b0;
      first_frame  <= 1'b0;
      frame_strobe <= 1'b0;
      frame_err    <= 1'b0;
      start_pulse  <= 1'b0;
    end else begin
      frame_strobe <= frame_done;                   // Pulses after word 3
      frame_err    <= 1'b0;
      start_pulse  <= frame_done && first_frame;
      case (state)
        HUNT: begin
          if (is_comma) begin                       // Any comma opens a frame
            state       <= LOCKED;
            pos         <= 1'b1;
            locked      <= 1'b1;
            first_frame <= 1'b1;
          end
        end
        LOCKED: begin
          if (violation) begin
            frame_err <= 1'b1;
            locked    <= 1'b0;                      // Lock lost
            if (is_comma) begin                     // Misplaced comma restarts at once
              pos         <= 1'b1;
              first_frame <= 1'b1;
            end else begin
              state <= HUNT;
              pos   <= '0;
            end
          end else begin
            locked <= 1'b1;
            pos    <= frame_done ? '0 : pos + 1'b1;
            if (frame_done) first_frame <= 1'b0;
          end
        end
      endcase
    end
  end

  // Payload path
  always_ff @(posedge clock) begin
    if (is_comma) k_hold <= word_data[7:0];       // Every accepted comma starts a frame
    if (!rx_word.is_k) held <= {held[0], word_data};
    if (frame_done) begin
      frame.k_char <= k_hold;
      frame.data   <= {held, word_data};          // MSW first
    end
  end

endmodule

`default_nettype wire

/* hdl/gem_rx_pkg.sv */
`default_nettype none

package gem_rx_pkg;

  localparam int NUM_FIBERS  = 2;               // Fibers per receiver
  localparam int DELAY_DEPTH = 16;              // Frame delay taps
  localparam int GOOD_FRAMES = 16;              // Clean frames before link_good
  localparam int BAD_ERRORS  = 8;               // Framing errors that mark link_bad

  typedef logic [3:0]  delay_t;                 // Delay in frames, 0..15
  typedef logic [7:0]  link_count_t;            // Link error count
  typedef logic [15:0] err_count_t;             // Reported error count

  typedef struct packed {
    logic       start;                          // First frame after lock
    logic       fc;                             // Latency code seen
    logic       valid;                          // Link framed
    logic       match;                          // PRBS payload matched
    logic       sync_done;                      // Link ready
    logic       err;                            // PRBS mismatch
    logic       link_had_err;                   // Sticky link error
    logic       link_good;
    logic       link_bad;
    err_count_t err_count;                      // PRBS or link errors
  } rx_status_s;

  typedef struct packed {
    logic overflow;
    logic bc0;
    logic resync;
  } rx_markers_s;

endpackage

`default_nettype wire

/* hdl/gem_link_pkg.sv */
`default_nettype none

package gem_link_pkg;

  // --------------------------------------------------------------------------
  // Link word as it leaves the deserializer
  // --------------------------------------------------------------------------
  typedef logic [15:0] link_data_t;             // One 16-bit link word

  typedef struct packed {
    logic       is_k;                           // Word carries a K character
    link_data_t data;                           // Word payload
  } link_word_s;

  // --------------------------------------------------------------------------
  // Frame of four words: comma/K word, then three data words MSW first
  // --------------------------------------------------------------------------
  typedef logic [7:0]  k_char_t;                // K character in lower byte of word 0
  typedef logic [47:0] gem_data_t;              // Payload of words 1..3

  typedef struct packed {
    k_char_t   k_char;                          // Marker code of this frame
    gem_data_t data;                            // Trigger payload
  } gem_frame_s;

  localparam int      FRAME_WORDS = 4;          // Words per frame

  localparam k_char_t K_COMMA     = 8'hBC;      // Upper byte of word 0
  localparam k_char_t K_OVERFLOW  = 8'hFC;      // Buffer overflow marker
  localparam k_char_t K_BC0       = 8'h1C;      // Bunch crossing zero
  localparam k_char_t K_RESYNC    = 8'h3C;      // Resync marker
  localparam k_char_t K_LATENCY   = 8'hF7;      // Latency measurement code

endpackage

`default_nettype wire
